// File: flist.f
logic/fetch_pkg.sv
logic/fetch_pc.sv
logic/insn_rom.sv
logic/fetch_stall_hold.sv
logic/insn_decode.sv
logic/fetch_frontend.sv
verification/fetch_frontend_assertions.sv
verification/fetch_frontend_tb.sv

// File: logic/fetch_frontend.sv
// Fetch front end top level.
// Counter, ROM, stall capture and decoder, plus the stall term.
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       redirect,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  input  logic                       out_ready,
  output logic                       out_valid,
  output logic [fetch_pkg::xlen-1:0] out_pc,
  output logic [6:0]                 out_opcode,
  output logic [4:0]                 out_rd,
  output logic [4:0]                 out_rs1,
  output logic [fetch_pkg::xlen-1:0] out_operand,
  output logic                       out_is_imm
);

  logic                       stall;
  logic [fetch_pkg::xlen-1:0] fetch_addr;
  logic                       fetch_req;
  logic                       rom_valid;
  logic [fetch_pkg::xlen-1:0] rom_addr;
  fetch_pkg::insn_t           rom_data;
  logic                       hold_valid;
  logic [fetch_pkg::xlen-1:0] hold_addr;
  fetch_pkg::insn_t           hold_data;

  // Consumer holding a presented word stalls the whole front end.
  assign stall = out_valid & ~out_ready;

  fetch_pc u_fetch_pc (
    .clk         (clk),
    .rst         (rst),
    .stall       (stall),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .fetch_addr  (fetch_addr),
    .fetch_req   (fetch_req)
  );

  insn_rom u_insn_rom (
    .clk        (clk),
    .rst        (rst),
    .flush      (redirect),
    .fetch_req  (fetch_req),
    .fetch_addr (fetch_addr),
    .rom_valid  (rom_valid),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data)
  );

  fetch_stall_hold u_fetch_stall_hold (
    .clk        (clk),
    .rst        (rst),
    .flush      (redirect),
    .stall      (stall),
    .rom_valid  (rom_valid),
    .rom_addr   (rom_addr),
    .rom_data   (rom_data),
    .hold_valid (hold_valid),
    .hold_addr  (hold_addr),
    .hold_data  (hold_data)
  );

  insn_decode u_insn_decode (
    .clk         (clk),
    .rst         (rst),
    .flush       (redirect),
    .stall       (stall),
    .hold_valid  (hold_valid),
    .hold_addr   (hold_addr),
    .hold_data   (hold_data),
    .out_valid   (out_valid),
    .out_pc      (out_pc),
    .out_opcode  (out_opcode),
    .out_rd      (out_rd),
    .out_rs1     (out_rs1),
    .out_operand (out_operand),
    .out_is_imm  (out_is_imm)
  );

endmodule

`default_nettype wire

// File: logic/fetch_pc.sv
// Fetch program counter.
// Issues one request per unstalled cycle, steps by four,
// loads the redirect target on a flush.
`timescale 1ns/1ps
`default_nettype none

module fetch_pc (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stall,
  input  logic                       redirect,
  input  logic [fetch_pkg::xlen-1:0] redirect_pc,
  output logic [fetch_pkg::xlen-1:0] fetch_addr,
  output logic                       fetch_req
);

  logic run; // Low until the first cycle after reset.

  // No request while stalled or while the target is being loaded.
  assign fetch_req = run & ~stall & ~redirect;

  always_ff @(posedge clk) begin
    if (rst) begin
      run        <= 1'b0;
      fetch_addr <= fetch_pkg::reset_pc;
    end else begin
      run <= 1'b1;
      if (redirect) begin
        fetch_addr <= redirect_pc; // Flush wins over stall.
      end else if (fetch_req) begin
        fetch_addr <= fetch_addr + 32'd4;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_pkg.sv
// Shared definitions for the fetch front end.
// Widths, reset PC, ROM latency and content constant,
// and the instruction word with its two decode views.
`default_nettype none

package fetch_pkg;

  localparam int xlen = 32; // Data and address width.
  localparam logic [xlen-1:0] reset_pc = 32'h0000_1000;
  localparam int rom_latency = 2; // Request to data, in cycles.

  // Opcode bit that marks the immediate format.
  localparam int op_imm_bit = 5;

  localparam logic [xlen-1:0] rom_mix = 32'h9e37_79b9; // ROM content multiplier.

  // Register format.
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } insn_r_t;

  // Immediate format.
  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } insn_i_t;

  typedef union packed {
    insn_r_t r;
    insn_i_t i;
  } insn_t;

endpackage

`default_nettype wire

// File: logic/fetch_stall_hold.sv
// Stall capture for fetch words still in flight.
// Two slots with one-hot position tags catch ROM words during
// a stall and replay them oldest first before the bypass path.
`timescale 1ns/1ps
`default_nettype none

module fetch_stall_hold (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush,
  input  logic                       stall,
  input  logic                       rom_valid,
  input  logic [fetch_pkg::xlen-1:0] rom_addr,
  input  fetch_pkg::insn_t           rom_data,
  output logic                       hold_valid,
  output logic [fetch_pkg::xlen-1:0] hold_addr,
  output fetch_pkg::insn_t           hold_data
);

  // Tag: 001 free, 010 queued behind the other slot, 100 oldest.
  logic [2:0]                 tag       [2];
  logic [fetch_pkg::xlen-1:0] slot_addr [2];
  fetch_pkg::insn_t           slot_data [2];

  logic       any_held;
  logic       old_sel;
  logic       push;
  logic       pop;
  logic [1:0] fill;

  assign any_held = tag[0][2] | tag[1][2]; // An oldest slot exists.
  assign old_sel  = tag[1][2];

  // Oldest slot leaves when the decoder takes it.
  assign pop  = any_held & ~stall;
  // A ROM word is caught unless it can go straight through.
  assign push = rom_valid & (stall | any_held);

  // First free slot takes the arriving word.
  assign fill[0] = push & tag[0][0];
  assign fill[1] = push & tag[1][0] & ~tag[0][0];

  assign hold_valid = any_held | rom_valid;
  assign hold_addr  = any_held ? slot_addr[old_sel] : rom_addr;
  assign hold_data  = any_held ? slot_data[old_sel] : rom_data;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      tag[0] <= 3'b001;
      tag[1] <= 3'b001;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (fill[i]) begin
          // Queued if an older word stays behind this cycle.
          tag[i] <= (any_held && !pop) ? 3'b010 : 3'b100;
        end else if (pop && !tag[i][0]) begin
          tag[i] <= {tag[i][1:0], tag[i][2]}; // 100 frees, 010 moves up.
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 2; i++) begin
      if (fill[i]) begin
        slot_addr[i] <= rom_addr;
        slot_data[i] <= rom_data;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/insn_decode.sv
// Instruction decoder and output register.
// Picks the register or immediate view of the word and builds
// the operand; outputs hold while the consumer stalls.
`timescale 1ns/1ps
`default_nettype none

module insn_decode (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush,
  input  logic                       stall,
  input  logic                       hold_valid,
  input  logic [fetch_pkg::xlen-1:0] hold_addr,
  input  fetch_pkg::insn_t           hold_data,
  output logic                       out_valid,
  output logic [fetch_pkg::xlen-1:0] out_pc,
  output logic [6:0]                 out_opcode,
  output logic [4:0]                 out_rd,
  output logic [4:0]                 out_rs1,
  output logic [fetch_pkg::xlen-1:0] out_operand,
  output logic                       out_is_imm
);

  logic                       is_imm;
  logic [fetch_pkg::xlen-1:0] operand;

  assign is_imm = hold_data.i.opcode[fetch_pkg::op_imm_bit];

  // Sign-extended immediate, or funct7 and rs2 zero-extended.
  assign operand = is_imm ?
    {{(fetch_pkg::xlen-12){hold_data.i.imm12[11]}}, hold_data.i.imm12} :
    {{(fetch_pkg::xlen-12){1'b0}}, hold_data.r.funct7, hold_data.r.rs2};

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      out_valid <= 1'b0;
    end else if (!stall) begin
      out_valid <= hold_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall && hold_valid) begin
      out_pc      <= hold_addr;
      out_opcode  <= hold_data.r.opcode; // Same place in both views.
      out_rd      <= hold_data.r.rd;
      out_rs1     <= hold_data.r.rs1;
      out_operand <= operand;
      out_is_imm  <= is_imm;
    end
  end

endmodule

`default_nettype wire

// File: logic/insn_rom.sv
// Pipelined read-only instruction memory.
// Word at an address is the address times a constant,
// rotated left by the word index bits.
`timescale 1ns/1ps
`default_nettype none

module insn_rom (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       flush,
  input  logic                       fetch_req,
  input  logic [fetch_pkg::xlen-1:0] fetch_addr,
  output logic                       rom_valid,
  output logic [fetch_pkg::xlen-1:0] rom_addr,
  output fetch_pkg::insn_t           rom_data
);

  logic [fetch_pkg::rom_latency-1:0] vld;
  logic [fetch_pkg::xlen-1:0]        addr_q [fetch_pkg::rom_latency];
  fetch_pkg::insn_t                  word_q;

  function automatic logic [fetch_pkg::xlen-1:0] mix_word(
    input logic [fetch_pkg::xlen-1:0] a
  );
    logic [fetch_pkg::xlen-1:0]   prod;
    logic [2*fetch_pkg::xlen-1:0] twice;
    prod  = a * fetch_pkg::rom_mix;
    twice = {prod, prod} << a[6:2]; // Upper half is the rotate.
    return twice[2*fetch_pkg::xlen-1:fetch_pkg::xlen];
  endfunction

  // Valid bits march with the request; a flush empties the pipe.
  always_ff @(posedge clk) begin
    if (rst || flush) begin
      vld <= '0;
    end else begin
      vld <= {vld[fetch_pkg::rom_latency-2:0], fetch_req};
    end
  end

  always_ff @(posedge clk) begin
    addr_q[0] <= fetch_addr;
    for (int i = 1; i < fetch_pkg::rom_latency; i++) begin
      addr_q[i] <= addr_q[i-1];
    end
    word_q <= mix_word(addr_q[fetch_pkg::rom_latency-2]); // Last stage reads.
  end

  assign rom_valid = vld[fetch_pkg::rom_latency-1];
  assign rom_addr  = addr_q[fetch_pkg::rom_latency-1];
  assign rom_data  = word_q;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f flist.f \
  --top-module fetch_frontend_tb -Mdir obj_dir -o fetch_frontend_sim \
  && { ./obj_dir/fetch_frontend_sim > sim.log 2>&1 || echo "TESTS FAILED" >> sim.log; } \
  && cat sim.log \
  && ! grep -q "TESTS FAILED" sim.log \
  && echo "Simulation run passed" \
  || { echo "Simulation run failed"; exit 1; }

// File: verification/fetch_frontend_assertions.sv
// Bound checks on the fetch front end outputs.
// Stable outputs under stall, flush clearing, quiet reset.
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_assertions (
  input logic                       clk,
  input logic                       rst,
  input logic                       redirect,
  input logic                       out_ready,
  input logic                       out_valid,
  input logic [fetch_pkg::xlen-1:0] out_pc,
  input logic [6:0]                 out_opcode,
  input logic [4:0]                 out_rd,
  input logic [4:0]                 out_rs1,
  input logic [fetch_pkg::xlen-1:0] out_operand,
  input logic                       out_is_imm
);

  // A presented word waits unchanged until taken.
  a_stable_under_stall: assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && !redirect |=> out_valid &&
      $stable({out_pc, out_opcode, out_rd, out_rs1, out_operand, out_is_imm}))
    else $error("Output changed while the consumer stalled");

  a_flush_clears: assert property (@(posedge clk) disable iff (rst)
    redirect |=> !out_valid)
    else $error("out_valid high in the cycle after a redirect");

  a_reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high during reset");

endmodule

bind fetch_frontend fetch_frontend_assertions u_fetch_frontend_assertions (
  .clk         (clk),
  .rst         (rst),
  .redirect    (redirect),
  .out_ready   (out_ready),
  .out_valid   (out_valid),
  .out_pc      (out_pc),
  .out_opcode  (out_opcode),
  .out_rd      (out_rd),
  .out_rs1     (out_rs1),
  .out_operand (out_operand),
  .out_is_imm  (out_is_imm)
);

`default_nettype wire

// File: verification/fetch_frontend_tb.sv
// Testbench for the fetch front end.
// Clock and reset, random back-pressure, stalls and redirects,
// reference decode model, comparing process and compare tasks.
`timescale 1ns/1ps
`default_nettype none

module fetch_frontend_tb;

  typedef struct packed {
    fetch_pkg::insn_t word;   // Expected word; funct3 is cleared as no output carries it.
    logic             is_imm;
    logic             sign;   // Expected top bit of the operand.
  } expect_t;

  logic                       clk;
  logic                       rst;
  logic                       redirect;
  logic [fetch_pkg::xlen-1:0] redirect_pc;
  logic                       out_ready;
  logic                       out_valid;
  logic [fetch_pkg::xlen-1:0] out_pc;
  logic [6:0]                 out_opcode;
  logic [4:0]                 out_rd;
  logic [4:0]                 out_rs1;
  logic [fetch_pkg::xlen-1:0] out_operand;
  logic                       out_is_imm;

  integer                     seed;
  string                      test_name;
  int                         mismatches = 0;
  int                         timeouts = 0;
  int                         other_errors = 0;
  int                         xfer_count = 0;
  int                         imm_seen = 0;
  int                         reg_seen = 0;
  int                         neg_seen = 0;
  int                         stall_len [3] = '{1, 2, 5};
  logic                       hung = 1'b0;
  logic [fetch_pkg::xlen-1:0] exp_pc; // Model of the next PC to transfer.
  expect_t                    exp_fields;
  fetch_pkg::insn_t           act_word;

  fetch_frontend u_fetch_frontend (
    .clk         (clk),
    .rst         (rst),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .out_ready   (out_ready),
    .out_valid   (out_valid),
    .out_pc      (out_pc),
    .out_opcode  (out_opcode),
    .out_rd      (out_rd),
    .out_rs1     (out_rs1),
    .out_operand (out_operand),
    .out_is_imm  (out_is_imm)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ROM word is the address times the mix constant, rotated left by addr[6:2].
  function automatic expect_t ref_decode(input logic [fetch_pkg::xlen-1:0] addr);
    logic [fetch_pkg::xlen-1:0] prod;
    logic [4:0]                 sh;
    fetch_pkg::insn_t           w;
    expect_t                    e;
    prod = addr * fetch_pkg::rom_mix;
    sh = addr[6:2];
    w = (prod << sh) | (prod >> (6'd32 - {1'b0, sh}));
    e.is_imm = w.i.opcode[fetch_pkg::op_imm_bit];
    e.sign = e.is_imm & w.i.imm12[11]; // Register operand is zero-extended.
    w.i.funct3 = 3'b000;
    e.word = w;
    return e;
  endfunction

  function automatic logic [fetch_pkg::xlen-1:0] find_addr(input logic imm, input logic sign);
    logic [fetch_pkg::xlen-1:0] a;
    expect_t                    e;
    a = 32'h0000_4000;
    for (int k = 0; k < 256; k++) begin
      e = ref_decode(a);
      if (e.is_imm == imm && e.sign == sign) return a;
      a = a + 32'd4;
    end
    return a;
  endfunction

  task automatic check_pc(input string what, input logic [fetch_pkg::xlen-1:0] exp, act);
    if (exp !== act) begin
      mismatches++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_insn(input string what, input fetch_pkg::insn_t exp, act);
    if (exp !== act) begin
      mismatches++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, act);
    if (exp !== act) begin
      mismatches++;
      $display("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // Waits for n more transfers; optionally toggles out_ready at random.
  task automatic wait_xfers(input int n, input int limit, input logic rnd);
    int target;
    int cycles;
    target = xfer_count + n;
    cycles = 0;
    while (!hung && xfer_count < target && cycles < limit) begin
      next_cycle();
      if (rnd) out_ready = ($random(seed) & 3) != 0;
      cycles++;
    end
    if (!hung && xfer_count < target) begin
      timeouts++;
      hung = 1'b1;
      $display("Timeout in %s: the front end stopped delivering words", test_name);
    end
  endtask

  task automatic redirect_to(input logic [fetch_pkg::xlen-1:0] target);
    redirect = 1'b1;
    redirect_pc = target;
    next_cycle();
    redirect = 1'b0;
  endtask

  // Sampled mid-cycle, where outputs and inputs are settled.
  always @(negedge clk) begin
    if (rst) begin
      exp_pc = fetch_pkg::reset_pc;
    end else begin
      if (out_valid && out_ready) begin
        exp_fields = ref_decode(exp_pc);
        act_word = {out_operand[11:0], out_rs1, 3'b000, out_rd, out_opcode};
        check_pc("pc", exp_pc, out_pc);
        check_insn("fields", exp_fields.word, act_word);
        check_flag("is_imm", exp_fields.is_imm, out_is_imm);
        check_flag("operand_sign", exp_fields.sign, out_operand[fetch_pkg::xlen-1]);
        check_flag("operand_fill", 1'b1, out_operand[31:12] == {20{out_operand[31]}});
        if (exp_fields.is_imm) imm_seen++;
        else reg_seen++;
        if (exp_fields.sign) neg_seen++;
        xfer_count++;
        exp_pc = exp_pc + 32'd4;
      end
      if (redirect) exp_pc = redirect_pc; // Nothing older may follow.
    end
  end

  initial begin
    seed = 32'h3dd2;
    rst = 1'b1;
    redirect = 1'b0;
    redirect_pc = '0;
    out_ready = 1'b0;
    test_name = "reset";
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;

    test_name = "free_flow";
    out_ready = 1'b1;
    wait_xfers(40, 200, 1'b0);
    test_name = "random_backpressure";
    wait_xfers(150, 2000, 1'b1);

    test_name = "long_stalls";
    foreach (stall_len[k]) begin
      out_ready = 1'b1;
      wait_xfers(1, 50, 1'b0);
      out_ready = 1'b0; // Stall right after a transfer.
      repeat (stall_len[k]) next_cycle();
      out_ready = 1'b1;
      wait_xfers(6, 50, 1'b0);
    end

    test_name = "redirect_held";
    out_ready = 1'b0;
    repeat (3) next_cycle(); // Both hold slots are full by now.
    redirect_to(32'h0000_2400);
    out_ready = 1'b1;
    wait_xfers(6, 50, 1'b0);
    test_name = "redirect_in_flight";
    redirect_to(32'h0000_3000);
    wait_xfers(6, 50, 1'b0);
    test_name = "redirect_random";
    wait_xfers(10, 200, 1'b1);
    redirect_to(32'h0000_0ffc);
    wait_xfers(20, 400, 1'b1);

    test_name = "format_decode";
    imm_seen = 0;
    reg_seen = 0;
    neg_seen = 0;
    out_ready = 1'b1;
    redirect_to(find_addr(1'b1, 1'b1)); // Negative immediate.
    wait_xfers(3, 50, 1'b0);
    redirect_to(find_addr(1'b1, 1'b0));
    wait_xfers(3, 50, 1'b0);
    redirect_to(find_addr(1'b0, 1'b0)); // Register format.
    wait_xfers(3, 50, 1'b0);
    if (imm_seen == 0 || reg_seen == 0 || neg_seen == 0) begin
      other_errors++;
      $display("Decode not covered: %0d immediate (%0d negative) and %0d register words",
               imm_seen, neg_seen, reg_seen);
    end

    $display("Errors: %0d mismatches, %0d timeouts, %0d other over %0d transfers",
             mismatches, timeouts, other_errors, xfer_count);
    if (mismatches + timeouts + other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
